//--- demux_settings.svh
// build-time sizes of the AXI write demux, included by the package and by RTL that needs them
`ifndef DEMUX_SETTINGS_SVH
`define DEMUX_SETTINGS_SVH

// number of master ports and the width of a port index
`define DEMUX_NUM_PORTS 4
`define DEMUX_SEL_W     2

// AXI field widths
`define DEMUX_ID_W      4
`define DEMUX_ADDR_W    32
`define DEMUX_DATA_W    32

// open W burst counter, saturates at all ones (7 bursts)
`define DEMUX_OPEN_W    3

`endif

//--- demux_pkg.sv
// shared types of the AXI write demux, compiled before every RTL file that names them
`include "demux_settings.svh"

package demux_pkg;

  // ----------------------------------------------------------------------
  // vector types
  // ----------------------------------------------------------------------
  // index of a master port
  typedef logic [`DEMUX_SEL_W-1:0]  port_sel_t;
  // AXI transaction id
  typedef logic [`DEMUX_ID_W-1:0]   axi_id_t;
  // write address
  typedef logic [`DEMUX_ADDR_W-1:0] addr_t;
  // one W data beat
  typedef logic [`DEMUX_DATA_W-1:0] data_t;
  // B response code (OKAY, EXOKAY, SLVERR, DECERR)
  typedef logic [1:0]               resp_t;
  // number of AW bursts whose W data is not done yet
  typedef logic [`DEMUX_OPEN_W-1:0] open_cnt_t;

  // ----------------------------------------------------------------------
  // AW dispatch states
  // ----------------------------------------------------------------------
  // idle: free to decide, locked: valid raised and waiting for ready
  typedef enum logic {
    AW_IDLE   = 1'b0,
    AW_LOCKED = 1'b1
  } aw_state_e;

endpackage

//--- burst_track_if.sv
// handshake bundle joining the AW dispatch FSM, the open-burst counter and the W beat router
`timescale 1ns/1ps

interface burst_track_if;

  // new burst issued on the AW side, with its port
  logic                 push;
  demux_pkg::port_sel_t push_sel;
  // last W beat of a burst accepted
  logic                 pop;
  // where W beats go right now
  demux_pkg::port_sel_t route_sel;
  logic                 route_valid;
  // counter status seen by the FSM
  logic                 full;
  logic                 idle;

  modport fsm     (output push, output push_sel, input route_sel, input full, input idle);
  modport tracker (input push, input push_sel, input pop,
                   output route_sel, output route_valid, output full, output idle);
  modport router  (input route_sel, input route_valid, output pop);

endinterface

//--- aw_dispatch_fsm.sv
// AW dispatch FSM: issues each write request to its master port once W ordering and space allow
`timescale 1ns/1ps
`include "demux_settings.svh"

module aw_dispatch_fsm (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        s_aw_valid_i,
  input  demux_pkg::port_sel_t        s_aw_sel_i,
  output logic                        s_aw_ready_o,
  input  logic [`DEMUX_NUM_PORTS-1:0] m_aw_ready_i,
  output logic [`DEMUX_NUM_PORTS-1:0] m_aw_valid_o,
  burst_track_if.fsm                  trk
);

  demux_pkg::aw_state_e state_q, state_d;
  demux_pkg::port_sel_t sel_q;
  demux_pkg::port_sel_t aw_sel;
  logic                 aw_valid;
  logic                 can_issue;

  // the counter records the port of the request under decision
  assign trk.push_sel = s_aw_sel_i;

  // room for another burst, and W data would not have to switch ports
  assign can_issue = !trk.full && (trk.idle || (trk.route_sel == s_aw_sel_i));

  // once locked, route by the captured select
  assign aw_sel = (state_q == demux_pkg::AW_LOCKED) ? sel_q : s_aw_sel_i;

  // ----------------------------------------------------------------------
  // next state and handshake
  // ----------------------------------------------------------------------
  always_comb begin
    state_d      = state_q;
    aw_valid     = 1'b0;
    s_aw_ready_o = 1'b0;
    trk.push     = 1'b0;
    case (state_q)
      demux_pkg::AW_IDLE: begin
        if (s_aw_valid_i && can_issue) begin
          aw_valid = 1'b1;
          // push on first issue only, the W data may start right away
          trk.push = 1'b1;
          if (m_aw_ready_i[aw_sel]) begin
            s_aw_ready_o = 1'b1;
          end else begin
            // valid is up now, it must stay up until ready
            state_d = demux_pkg::AW_LOCKED;
          end
        end
      end
      demux_pkg::AW_LOCKED: begin
        aw_valid = 1'b1;
        if (m_aw_ready_i[aw_sel]) begin
          s_aw_ready_o = 1'b1;
          state_d      = demux_pkg::AW_IDLE;
        end
      end
      default: state_d = demux_pkg::AW_IDLE;
    endcase
  end

  // one-hot valid towards the selected master
  always_comb begin
    m_aw_valid_o         = '0;
    m_aw_valid_o[aw_sel] = aw_valid;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= demux_pkg::AW_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // capture the port when a request has to wait
  always_ff @(posedge clk_i) begin
    if ((state_q == demux_pkg::AW_IDLE) && (state_d == demux_pkg::AW_LOCKED)) begin
      sel_q <= s_aw_sel_i;
    end
  end

endmodule

//--- w_burst_tracker.sv
// open W burst counter: counts issued AW bursts not yet closed by a last beat and steers W data
`timescale 1ns/1ps

module w_burst_tracker (
  input  logic          clk_i,
  input  logic          rst_n_i,
  burst_track_if.tracker trk
);

  demux_pkg::open_cnt_t cnt_q;
  demux_pkg::port_sel_t sel_q;

  // ----------------------------------------------------------------------
  // burst count
  // ----------------------------------------------------------------------
  // push and pop together leave the count as it is
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (trk.push && !trk.pop) begin
      cnt_q <= cnt_q + demux_pkg::open_cnt_t'(1);
    end else if (!trk.push && trk.pop) begin
      cnt_q <= cnt_q - demux_pkg::open_cnt_t'(1);
    end
  end

  // all open bursts share one port, so one register is enough
  always_ff @(posedge clk_i) begin
    if (trk.push) begin
      sel_q <= trk.push_sel;
    end
  end

  // ----------------------------------------------------------------------
  // status and routing
  // ----------------------------------------------------------------------
  assign trk.idle = (cnt_q == '0);
  // all ones means no room left
  assign trk.full = &cnt_q;

  // with nothing open, route straight from the request being pushed
  assign trk.route_sel   = trk.idle ? trk.push_sel : sel_q;
  assign trk.route_valid = trk.push | !trk.idle;

endmodule

//--- w_beat_router.sv
// W beat router: connects the slave W handshake to the current target port and flags burst ends
`timescale 1ns/1ps
`include "demux_settings.svh"

module w_beat_router (
  input  logic                        s_w_valid_i,
  input  logic                        s_w_last_i,
  output logic                        s_w_ready_o,
  input  logic [`DEMUX_NUM_PORTS-1:0] m_w_ready_i,
  output logic [`DEMUX_NUM_PORTS-1:0] m_w_valid_o,
  burst_track_if.router               trk
);

  // ----------------------------------------------------------------------
  // handshake steering
  // ----------------------------------------------------------------------
  // no known target means the beat waits at the slave side
  always_comb begin
    m_w_valid_o = '0;
    if (trk.route_valid) begin
      m_w_valid_o[trk.route_sel] = s_w_valid_i;
    end
  end

  // ready comes back only from the port being routed to
  assign s_w_ready_o = trk.route_valid & m_w_ready_i[trk.route_sel];

  // burst closes on the accepted last beat
  assign trk.pop = s_w_valid_i & s_w_ready_o & s_w_last_i;

endmodule

//--- b_resp_arbiter.sv
// B response arbiter of the write demux top that merges master responses round-robin and holds the grant while the slave stalls
`timescale 1ns/1ps
`include "demux_settings.svh"

module b_resp_arbiter (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  logic                     [`DEMUX_NUM_PORTS-1:0] m_b_valid_i,
  input  demux_pkg::axi_id_t       [`DEMUX_NUM_PORTS-1:0] m_b_id_i,
  input  demux_pkg::resp_t         [`DEMUX_NUM_PORTS-1:0] m_b_resp_i,
  output logic                     [`DEMUX_NUM_PORTS-1:0] m_b_ready_o,
  output logic                                          s_b_valid_o,
  output demux_pkg::axi_id_t                            s_b_id_o,
  output demux_pkg::resp_t                              s_b_resp_o,
  input  logic                                          s_b_ready_i
);

  demux_pkg::port_sel_t ptr_q;
  demux_pkg::port_sel_t next_ptr;
  demux_pkg::port_sel_t rr_idx;
  demux_pkg::port_sel_t gnt_idx;
  demux_pkg::port_sel_t lock_idx_q;
  logic                 lock_q;

  // ----------------------------------------------------------------------
  // round-robin search
  // ----------------------------------------------------------------------
  // first valid port at or after the pointer
  always_comb begin : rr_search
    int unsigned idx;
    logic        found;
    rr_idx = ptr_q;
    found  = 1'b0;
    for (int unsigned k = 0; k < `DEMUX_NUM_PORTS; k++) begin
      idx = (int'(ptr_q) + k) % `DEMUX_NUM_PORTS;
      if (!found && m_b_valid_i[idx]) begin
        found  = 1'b1;
        rr_idx = demux_pkg::port_sel_t'(idx);
      end
    end
  end

  // a stalled response keeps its grant
  assign gnt_idx = lock_q ? lock_idx_q : rr_idx;

  assign s_b_valid_o = m_b_valid_i[gnt_idx];
  assign s_b_id_o    = m_b_id_i[gnt_idx];
  assign s_b_resp_o  = m_b_resp_i[gnt_idx];

  always_comb begin
    m_b_ready_o          = '0;
    m_b_ready_o[gnt_idx] = s_b_valid_o & s_b_ready_i;
  end

  // port after the winner gets top priority next
  assign next_ptr = (int'(gnt_idx) == `DEMUX_NUM_PORTS - 1) ? '0 :
                    gnt_idx + demux_pkg::port_sel_t'(1);

  // ----------------------------------------------------------------------
  // pointer and lock-in
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q  <= '0;
      lock_q <= 1'b0;
    end else if (s_b_valid_o && s_b_ready_i) begin
      ptr_q  <= next_ptr;
      lock_q <= 1'b0;
    end else if (s_b_valid_o) begin
      lock_q <= 1'b1;
    end
  end

  // remember which port won when the slave first stalls
  always_ff @(posedge clk_i) begin
    if (s_b_valid_o && !s_b_ready_i && !lock_q) begin
      lock_idx_q <= gnt_idx;
    end
  end

endmodule

//--- axi_write_demux.sv
// AXI4 write demux top: one write slave port routed to DEMUX_NUM_PORTS write master ports
`timescale 1ns/1ps
`include "demux_settings.svh"

module axi_write_demux (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  // slave AW
  input  logic                                    s_aw_valid_i,
  output logic                                    s_aw_ready_o,
  input  demux_pkg::addr_t                        s_aw_addr_i,
  input  demux_pkg::axi_id_t                      s_aw_id_i,
  input  demux_pkg::port_sel_t                    s_aw_sel_i,
  // slave W
  input  logic                                    s_w_valid_i,
  output logic                                    s_w_ready_o,
  input  demux_pkg::data_t                        s_w_data_i,
  input  logic                                    s_w_last_i,
  // slave B
  output logic                                    s_b_valid_o,
  input  logic                                    s_b_ready_i,
  output demux_pkg::axi_id_t                      s_b_id_o,
  output demux_pkg::resp_t                        s_b_resp_o,
  // master AW
  output logic               [`DEMUX_NUM_PORTS-1:0] m_aw_valid_o,
  input  logic               [`DEMUX_NUM_PORTS-1:0] m_aw_ready_i,
  output demux_pkg::addr_t                        m_aw_addr_o,
  output demux_pkg::axi_id_t                      m_aw_id_o,
  // master W
  output logic               [`DEMUX_NUM_PORTS-1:0] m_w_valid_o,
  input  logic               [`DEMUX_NUM_PORTS-1:0] m_w_ready_i,
  output demux_pkg::data_t                        m_w_data_o,
  output logic                                    m_w_last_o,
  // master B
  input  logic               [`DEMUX_NUM_PORTS-1:0] m_b_valid_i,
  output logic               [`DEMUX_NUM_PORTS-1:0] m_b_ready_o,
  input  demux_pkg::axi_id_t [`DEMUX_NUM_PORTS-1:0] m_b_id_i,
  input  demux_pkg::resp_t   [`DEMUX_NUM_PORTS-1:0] m_b_resp_i
);

  // ties AW decisions to W routing
  burst_track_if track_bus ();

  // ----------------------------------------------------------------------
  // shared payload, only the valids are per port
  // ----------------------------------------------------------------------
  assign m_aw_addr_o = s_aw_addr_i;
  assign m_aw_id_o   = s_aw_id_i;
  assign m_w_data_o  = s_w_data_i;
  assign m_w_last_o  = s_w_last_i;

  aw_dispatch_fsm aw_dispatch_fsm_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .s_aw_valid_i (s_aw_valid_i),
    .s_aw_sel_i   (s_aw_sel_i),
    .s_aw_ready_o (s_aw_ready_o),
    .m_aw_ready_i (m_aw_ready_i),
    .m_aw_valid_o (m_aw_valid_o),
    .trk          (track_bus.fsm)
  );

  w_burst_tracker w_burst_tracker_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .trk     (track_bus.tracker)
  );

  w_beat_router w_beat_router_inst (
    .s_w_valid_i (s_w_valid_i),
    .s_w_last_i  (s_w_last_i),
    .s_w_ready_o (s_w_ready_o),
    .m_w_ready_i (m_w_ready_i),
    .m_w_valid_o (m_w_valid_o),
    .trk         (track_bus.router)
  );

  // B responses are not tied to AW order
  b_resp_arbiter b_resp_arbiter_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .m_b_valid_i (m_b_valid_i),
    .m_b_id_i    (m_b_id_i),
    .m_b_resp_i  (m_b_resp_i),
    .m_b_ready_o (m_b_ready_o),
    .s_b_valid_o (s_b_valid_o),
    .s_b_id_o    (s_b_id_o),
    .s_b_resp_o  (s_b_resp_o),
    .s_b_ready_i (s_b_ready_i)
  );

endmodule

//--- tb_clk_gen.sv
// testbench clock source, free-running from time zero with a settable period in ns
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 8
) (
  output logic clk_o
);

  // low for the first half period, then toggles forever
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0);
      clk_o = ~clk_o;
    end
  end

endmodule

//--- tb_axi_write_demux.sv
// top-level testbench that drives random write traffic into the AXI write demux and checks each cycle against reference models
`timescale 1ns/1ps
`include "demux_settings.svh"

module tb_axi_write_demux;

  localparam int          NP       = `DEMUX_NUM_PORTS;
  localparam int          N_TXN    = 200;
  localparam int          CLK_NS   = 8;
  localparam int          MAX_OPEN = (1 << `DEMUX_OPEN_W) - 1;
  // 40 cycles per transaction is far above the expected average
  localparam int          WDOG_NS  = N_TXN * 40 * CLK_NS;
  localparam logic [31:0] SEED     = 32'h8048;

  logic                                    clk_i;
  logic                                    rst_n_i;
  logic                                    s_aw_valid_i;
  logic                                    s_aw_ready_o;
  demux_pkg::addr_t                        s_aw_addr_i;
  demux_pkg::axi_id_t                      s_aw_id_i;
  demux_pkg::port_sel_t                    s_aw_sel_i;
  logic                                    s_w_valid_i;
  logic                                    s_w_ready_o;
  demux_pkg::data_t                        s_w_data_i;
  logic                                    s_w_last_i;
  logic                                    s_b_valid_o;
  logic                                    s_b_ready_i;
  demux_pkg::axi_id_t                      s_b_id_o;
  demux_pkg::resp_t                        s_b_resp_o;
  logic               [NP-1:0]             m_aw_valid_o;
  logic               [NP-1:0]             m_aw_ready_i;
  demux_pkg::addr_t                        m_aw_addr_o;
  demux_pkg::axi_id_t                      m_aw_id_o;
  logic               [NP-1:0]             m_w_valid_o;
  logic               [NP-1:0]             m_w_ready_i;
  demux_pkg::data_t                        m_w_data_o;
  logic                                    m_w_last_o;
  logic               [NP-1:0]             m_b_valid_i;
  logic               [NP-1:0]             m_b_ready_o;
  demux_pkg::axi_id_t [NP-1:0]             m_b_id_i;
  demux_pkg::resp_t   [NP-1:0]             m_b_resp_i;

  // stimulus with one entry per write transaction
  demux_pkg::port_sel_t st_sel  [N_TXN];
  int                   st_len  [N_TXN];
  demux_pkg::addr_t     st_addr [N_TXN];
  demux_pkg::axi_id_t   st_id   [N_TXN];

  // reference state of the checker
  // ports of issued bursts whose W data is still open, oldest first
  demux_pkg::port_sel_t open_q [$];
  int                   aw_k         = 0;
  int                   w_k          = 0;
  int                   w_beat       = 0;
  int                   b_count      = 0;
  logic                 aw_pend      = 1'b0;
  logic [NP-1:0]        aw_pend_vec  = '0;
  demux_pkg::port_sel_t rr_ptr       = '0;
  demux_pkg::port_sel_t rr_lock_port = '0;
  logic                 rr_lock      = 1'b0;

  tb_clk_gen #(.PERIOD_NS(CLK_NS)) clk_gen_inst (.clk_o(clk_i));

  axi_write_demux axi_write_demux_inst (.*);

  // ----------------------------------------------------------------------
  // helpers and reference functions
  // ----------------------------------------------------------------------
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // data of beat b in burst k
  function automatic demux_pkg::data_t beat_data(input int k, input int b);
    return demux_pkg::data_t'(32'hA500_0000 ^ (k << 8) ^ b);
  endfunction

  function automatic logic [NP-1:0] port_mask(input demux_pkg::port_sel_t p);
    logic [NP-1:0] m;
    m    = '0;
    m[p] = 1'b1;
    return m;
  endfunction

  // an AW may go out if there is room and W data keeps to one port
  function automatic logic aw_allowed(input int open, input demux_pkg::port_sel_t open_port,
                                      input demux_pkg::port_sel_t sel);
    return (open < MAX_OPEN) && ((open == 0) || (open_port == sel));
  endfunction

  // held grant wins, else first waiting port counting up from the pointer
  function automatic demux_pkg::port_sel_t expected_grant(input demux_pkg::port_sel_t ptr,
      input logic locked, input demux_pkg::port_sel_t lock_port, input logic [NP-1:0] valid);
    demux_pkg::port_sel_t g;
    int                   idx;
    g = ptr;
    if (locked) begin
      return lock_port;
    end
    for (int k = NP - 1; k >= 0; k--) begin
      idx = (int'(ptr) + k) % NP;
      if (valid[idx]) begin
        g = demux_pkg::port_sel_t'(idx);
      end
    end
    return g;
  endfunction

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      stop_run($sformatf("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // inputs change 1 ns after the rising edge
  task automatic next_drive_slot();
    @(posedge clk_i);
    #1;
  endtask

  // ----------------------------------------------------------------------
  // drivers and master models
  // ----------------------------------------------------------------------
  task automatic drive_aw();
    logic [31:0] rng;
    logic        fire;
    rng = SEED ^ 32'h1;
    for (int k = 0; k < N_TXN; k++) begin
      rng = lcg_step(rng);
      if (rng[31:30] == 2'b00) begin
        s_aw_valid_i = 1'b0;
        next_drive_slot();
      end
      s_aw_valid_i = 1'b1;
      s_aw_addr_i  = st_addr[k];
      s_aw_id_i    = st_id[k];
      s_aw_sel_i   = st_sel[k];
      fire         = 1'b0;
      // valid and payload held until the handshake
      while (!fire) begin
        @(negedge clk_i);
        fire = s_aw_ready_o;
        next_drive_slot();
      end
    end
    s_aw_valid_i = 1'b0;
  endtask

  task automatic drive_w();
    logic [31:0] rng;
    logic        fire;
    rng = SEED ^ 32'h2;
    for (int k = 0; k < N_TXN; k++) begin
      for (int b = 0; b < st_len[k]; b++) begin
        rng = lcg_step(rng);
        // frequent gaps let AW run ahead and fill the open count
        if (rng[31]) begin
          s_w_valid_i = 1'b0;
          next_drive_slot();
        end
        s_w_valid_i = 1'b1;
        s_w_data_i  = beat_data(k, b);
        s_w_last_i  = (b == st_len[k] - 1);
        fire        = 1'b0;
        while (!fire) begin
          @(negedge clk_i);
          fire = s_w_ready_o;
          next_drive_slot();
        end
      end
    end
    s_w_valid_i = 1'b0;
  endtask

  // one B per accepted AW, per port in AW order, after 1 to 7 cycles
  task automatic drive_masters();
    demux_pkg::axi_id_t pend_id  [NP][N_TXN];
    int                 pend_due [NP][N_TXN];
    int                 wr_idx   [NP];
    int                 rd_idx   [NP];
    logic [NP-1:0]      b_taken;
    logic [31:0]        rng;
    int                 cyc;
    rng = SEED ^ 32'h3;
    cyc = 0;
    for (int p = 0; p < NP; p++) begin
      wr_idx[p] = 0;
      rd_idx[p] = 0;
    end
    forever begin
      @(negedge clk_i);
      for (int p = 0; p < NP; p++) begin
        if (m_aw_valid_o[p] && m_aw_ready_i[p]) begin
          rng                    = lcg_step(rng);
          pend_id[p][wr_idx[p]]  = m_aw_id_o;
          pend_due[p][wr_idx[p]] = cyc + int'(rng[31:29]);
          wr_idx[p]++;
        end
        b_taken[p] = m_b_valid_i[p] && m_b_ready_o[p];
      end
      next_drive_slot();
      cyc++;
      for (int p = 0; p < NP; p++) begin
        rng             = lcg_step(rng);
        m_aw_ready_i[p] = (rng[31:30] != 2'b00);
        m_w_ready_i[p]  = (rng[29:28] != 2'b00);
        if (b_taken[p]) begin
          m_b_valid_i[p] = 1'b0;
          rd_idx[p]++;
        end
        if (!m_b_valid_i[p] && (rd_idx[p] != wr_idx[p]) && (cyc >= pend_due[p][rd_idx[p]])) begin
          m_b_valid_i[p] = 1'b1;
          m_b_id_i[p]    = pend_id[p][rd_idx[p]];
          m_b_resp_i[p]  = rng[27:26];
        end
      end
    end
  endtask

  task automatic drive_b_ready();
    logic [31:0] rng;
    rng = SEED ^ 32'h4;
    forever begin
      rng         = lcg_step(rng);
      s_b_ready_i = rng[31];
      next_drive_slot();
    end
  endtask

  // ----------------------------------------------------------------------
  // compare at the falling edge where everything is settled
  // ----------------------------------------------------------------------
  always @(negedge clk_i) begin : compare
    logic                 issue;
    logic                 b_fire;
    logic [NP-1:0]        aw_exp;
    logic [NP-1:0]        exp_vec;
    demux_pkg::port_sel_t g;
    if (rst_n_i) begin
      // a raised AW valid stays put and a new one goes out only where the rules allow
      if (aw_pend) begin
        aw_exp = aw_pend_vec;
      end else begin
        issue = s_aw_valid_i && aw_allowed(open_q.size(),
                                           (open_q.size() > 0) ? open_q[$] : '0, st_sel[aw_k]);
        aw_exp = issue ? port_mask(st_sel[aw_k]) : '0;
        if (issue) begin
          open_q.push_back(st_sel[aw_k]);
        end
      end
      check_eq("m_aw_valid_o", m_aw_valid_o, aw_exp);
      if (|aw_exp) begin
        check_eq("m_aw_addr_o", m_aw_addr_o, st_addr[aw_k]);
        check_eq("m_aw_id_o", m_aw_id_o, st_id[aw_k]);
      end
      check_eq("s_aw_ready_o", s_aw_ready_o, |(aw_exp & m_aw_ready_i));
      if (|(aw_exp & m_aw_ready_i)) begin
        aw_pend = 1'b0;
        aw_k++;
      end else if (|aw_exp) begin
        aw_pend     = 1'b1;
        aw_pend_vec = aw_exp;
      end
      // W beats only go to the oldest open burst's port
      exp_vec = (s_w_valid_i && (open_q.size() > 0)) ? port_mask(open_q[0]) : '0;
      check_eq("m_w_valid_o", m_w_valid_o, exp_vec);
      if (s_w_valid_i) begin
        check_eq("s_w_ready_o", s_w_ready_o, |(exp_vec & m_w_ready_i));
      end
      if (|exp_vec) begin
        check_eq("m_w_data_o", m_w_data_o, beat_data(w_k, w_beat));
        check_eq("m_w_last_o", m_w_last_o, w_beat == st_len[w_k] - 1);
        if (|(exp_vec & m_w_ready_i)) begin
          if (w_beat == st_len[w_k] - 1) begin
            void'(open_q.pop_front());
            w_k++;
            w_beat = 0;
          end else begin
            w_beat++;
          end
        end
      end
      // B grant follows the round-robin pointer and holds while the slave stalls
      g = expected_grant(rr_ptr, rr_lock, rr_lock_port, m_b_valid_i);
      check_eq("s_b_valid_o", s_b_valid_o, m_b_valid_i[g]);
      if (m_b_valid_i[g]) begin
        check_eq("s_b_id_o", s_b_id_o, m_b_id_i[g]);
        check_eq("s_b_resp_o", s_b_resp_o, m_b_resp_i[g]);
      end
      b_fire = m_b_valid_i[g] && s_b_ready_i;
      check_eq("m_b_ready_o", m_b_ready_o, b_fire ? port_mask(g) : '0);
      if (b_fire) begin
        rr_ptr  = demux_pkg::port_sel_t'((int'(g) + 1) % NP);
        rr_lock = 1'b0;
        b_count++;
      end else if (m_b_valid_i[g]) begin
        if (!rr_lock) begin
          rr_lock_port = g;
        end
        rr_lock = 1'b1;
      end
    end
  end

  initial begin : watchdog
    #(WDOG_NS);
    stop_run("watchdog expired before all transactions completed");
  end

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin : main
    logic [31:0] rng;
    rst_n_i      = 1'b0;
    s_aw_valid_i = 1'b0;
    s_aw_addr_i  = '0;
    s_aw_id_i    = '0;
    s_aw_sel_i   = '0;
    s_w_valid_i  = 1'b0;
    s_w_data_i   = '0;
    s_w_last_i   = 1'b0;
    // readies start high so that only the reset state keeps the outputs low
    s_b_ready_i  = 1'b1;
    m_aw_ready_i = '1;
    m_w_ready_i  = '1;
    m_b_valid_i  = '0;
    m_b_id_i     = '0;
    m_b_resp_i   = '0;
    // sticky port select so that bursts pile up on one port
    rng = SEED;
    for (int k = 0; k < N_TXN; k++) begin
      rng        = lcg_step(rng);
      st_sel[k]  = ((k == 0) || (rng[31:30] == 2'b00)) ? rng[29:28] : st_sel[k-1];
      st_len[k]  = int'(rng[27:26]) + 1;
      st_id[k]   = rng[19:16];
      st_addr[k] = {rng[25:4], 10'h000} + demux_pkg::addr_t'(k);
    end
    // reset held for three cycles with the outputs checked inside it
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_eq("m_aw_valid_o", m_aw_valid_o, '0);
    check_eq("m_w_valid_o", m_w_valid_o, '0);
    check_eq("m_b_ready_o", m_b_ready_o, '0);
    check_eq("s_aw_ready_o", s_aw_ready_o, '0);
    check_eq("s_w_ready_o", s_w_ready_o, '0);
    check_eq("s_b_valid_o", s_b_valid_o, '0);
    next_drive_slot();
    rst_n_i = 1'b1;
    fork
      drive_aw();
      drive_w();
      drive_masters();
      drive_b_ready();
    join_none
    wait ((b_count == N_TXN) && (w_k == N_TXN));
    // quiet period in which no stray response may show up
    repeat (20) @(posedge clk_i);
    if ((b_count == N_TXN) && (aw_k == N_TXN) && (open_q.size() == 0)) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      stop_run("run ended with missing or extra transactions");
    end
  end

endmodule

//--- vlog.f
+incdir+.
demux_pkg.sv
burst_track_if.sv
aw_dispatch_fsm.sv
w_burst_tracker.sv
w_beat_router.sv
b_resp_arbiter.sv
axi_write_demux.sv
tb_clk_gen.sv
tb_axi_write_demux.sv

//--- Makefile
# Verilator build and run of the AXI write demux testbench
# any variable can be set on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
TB_TOP    ?= tb_axi_write_demux
RTL_TOP   ?= axi_write_demux
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
